/* design/sys_pkg.sv */
package sys_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Audio path widths

	// One audio sample, core or Linux PCM or output
	typedef logic [15:0] sample_t;

	// Working sum, one bit of headroom over a sample
	typedef logic signed [16:0] mix_acc_t;

	// Bit 4 mutes, bits 3:0 give the right shift
	typedef logic [4:0] att_t;

	// Cross-feed mode between left and right
	typedef logic [1:0] mix_t;

	////////////////////////////////////////////////////////////////////////////
	// Host channel

	typedef logic [15:0] host_word_t;
	typedef logic [7:0]  led_t;
	typedef logic [7:0]  cmd_code_t;

	// Mask in high byte, state in low byte
	localparam cmd_code_t CMD_LED    = 8'h25;
	// Attenuation in bits 4:0
	localparam cmd_code_t CMD_VOLUME = 8'h26;

	// Decoder waits for the command word, then takes arguments
	typedef enum logic {
		CMD_IDLE,
		CMD_ARG
	} cmd_state_t;

endpackage

/* design/host_cmd.sv */
`timescale 1ns/1ns

module host_cmd
	import sys_pkg::*;
(
	input  logic       clk,
	input  logic       resetd,
	input  logic       i_io_clk,
	input  logic       i_io_uio,
	input  host_word_t i_io_din,
	output logic       o_io_ack,
	output att_t       o_vol_att,
	output led_t       o_led_overtake,
	output led_t       o_led_state
);

	logic       io_clk_d;
	logic       io_clk_r;
	logic       uio_d;
	logic       uio_r;
	host_word_t din_d;
	host_word_t din_r;
	logic       rack;
	logic       word_stb;
	cmd_state_t state;
	cmd_code_t  cmd;

	////////////////////////////////////////////////////////////////////////////
	// Bus synchronizer

	always_ff @(posedge clk) begin
		if (resetd) begin
			io_clk_d <= 1'b0;
			io_clk_r <= 1'b0;
			uio_d    <= 1'b0;
			uio_r    <= 1'b0;
		end else begin
			io_clk_d <= i_io_clk;
			io_clk_r <= io_clk_d;
			uio_d    <= i_io_uio;
			uio_r    <= uio_d;
		end
	end

	// Data is held by the host until ack, two stages keep it aligned
	always_ff @(posedge clk) begin
		din_d <= i_io_din;
		din_r <= din_d;
	end

	// Ack trails the synchronized strobe, word_stb marks its rising edge
	always_ff @(posedge clk) begin
		if (resetd) begin
			rack     <= 1'b0;
			o_io_ack <= 1'b0;
			word_stb <= 1'b0;
		end else begin
			rack     <= io_clk_r;
			o_io_ack <= rack;
			word_stb <= io_clk_r & ~rack;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Command decoder

	// First word of a transfer
	always_ff @(posedge clk) begin
		if (word_stb && uio_r && state == CMD_IDLE)
			cmd <= din_r[7:0];
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			state          <= CMD_IDLE;
			o_vol_att      <= '0;
			o_led_overtake <= '0;
			o_led_state    <= '0;
		end else if (!uio_r) begin
			state <= CMD_IDLE;
		end else if (word_stb) begin
			case (state)
				CMD_IDLE: state <= CMD_ARG;
				CMD_ARG: begin
					// Unknown commands eat their arguments
					if (cmd == CMD_LED)
						{o_led_overtake, o_led_state} <= din_r;
					if (cmd == CMD_VOLUME)
						o_vol_att <= din_r[4:0];
				end
				default: state <= CMD_IDLE;
			endcase
		end
	end

endmodule

/* design/audio_mix_channel.sv */
`timescale 1ns/1ns

module audio_mix_channel
	import sys_pkg::*;
(
	input  logic    clk,
	input  logic    resetd,
	input  att_t    i_att,
	input  mix_t    i_mix,
	input  logic    i_is_signed,
	input  sample_t i_core,
	input  sample_t i_linux,
	input  sample_t i_pre_in,
	output sample_t o_pre_out,
	output sample_t o_out
);

	sample_t  core_d1;
	sample_t  core_d2;
	sample_t  core_d3;
	sample_t  core_s;
	mix_acc_t linux_ext;
	mix_acc_t pre_ext;
	mix_acc_t a1;
	mix_acc_t a2;
	mix_acc_t a3;
	mix_acc_t a4;

	assign linux_ext = {i_linux[15], i_linux};
	assign pre_ext   = {i_pre_in[15], i_pre_in};

	// Half of the PCM sum, straight off the adder stage
	assign o_pre_out = a2[16:1];

	// Core sample is taken once two delayed copies agree
	always_ff @(posedge clk) begin
		if (resetd) begin
			core_d1 <= '0;
			core_d2 <= '0;
			core_d3 <= '0;
			core_s  <= '0;
		end else begin
			core_d1 <= i_core;
			core_d2 <= core_d1;
			core_d3 <= core_d2;
			if (core_d2 == core_d3)
				core_s <= core_d2;
		end
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			a1    <= '0;
			a2    <= '0;
			a3    <= '0;
			a4    <= '0;
			o_out <= '0;
		end else begin
			// Unsigned core input is halved to fit the signed range
			a1 <= i_is_signed ? {core_s[15], core_s} : {2'b00, core_s[15:1]};
			a2 <= a1 + linux_ext;

			case (i_mix)
				2'd0: a3 <= a2;
				2'd1: a3 <= a2 - (a2 >>> 3) + (pre_ext >>> 2);
				2'd2: a3 <= a2 - (a2 >>> 2) + (pre_ext >>> 1);
				default: a3 <= (a2 >>> 1) + pre_ext;
			endcase

			if (i_att[4])
				a4 <= '0;
			else
				a4 <= a3 >>> i_att[3:0];

			// Saturate on overflow of the top bit
			o_out <= (a4[16] ^ a4[15]) ? {a4[16], {15{a4[15]}}} : a4[15:0];
		end
	end

endmodule

/* design/btn_debounce.sv */
`timescale 1ns/1ns

module btn_debounce #(
	parameter int DEB_DIV = 100000
) (
	input  logic clk,
	input  logic resetd,
	input  logic i_btn,
	output logic o_btn
);

	localparam int DIV_W = (DEB_DIV > 0) ? $clog2(DEB_DIV + 1) : 1;

	logic [DIV_W-1:0] div;
	logic [7:0]       hist;

	always_ff @(posedge clk) begin
		if (resetd) begin
			div   <= '0;
			hist  <= '0;
			o_btn <= 1'b0;
		end else begin
			// Prescaler, one sample per DEB_DIV+1 clocks
			if (div == DIV_W'(DEB_DIV))
				div <= '0;
			else
				div <= div + 1'b1;

			if (div == '0) begin
				hist <= {hist[6:0], i_btn};
				// Hysteresis, holds on a mixed history
				if (&hist)
					o_btn <= 1'b1;
				else if (hist == '0)
					o_btn <= 1'b0;
			end
		end
	end

endmodule

/* design/panel_io.sv */
`timescale 1ns/1ns

module panel_io
	import sys_pkg::*;
#(
	parameter int DEB_DIV = 100000
) (
	input  logic       clk,
	input  logic       resetd,
	input  logic       i_key_user_n,
	input  logic       i_key_osd_n,
	input  logic [1:0] i_core_btn,
	input  logic       i_led_user,
	input  logic [1:0] i_led_power,
	input  logic [1:0] i_led_disk,
	input  led_t       i_led_overtake,
	input  led_t       i_led_state,
	output logic       o_btn_user,
	output logic       o_btn_osd,
	output led_t       o_led
);

	logic deb_user;
	logic deb_osd;
	logic led_p;
	logic led_d;
	led_t status;

	// Board keys are active low
	btn_debounce #(.DEB_DIV(DEB_DIV)) u_deb_user (
		.clk    (clk),
		.resetd (resetd),
		.i_btn  (~i_key_user_n),
		.o_btn  (deb_user)
	);

	btn_debounce #(.DEB_DIV(DEB_DIV)) u_deb_osd (
		.clk    (clk),
		.resetd (resetd),
		.i_btn  (~i_key_osd_n),
		.o_btn  (deb_osd)
	);

	// Core buttons bypass the debouncer
	assign o_btn_user = deb_user | i_core_btn[1];
	assign o_btn_osd  = deb_osd | i_core_btn[0];

	// Power lights only when the top bit selects a set bottom bit
	assign led_p  = i_led_power[1] & i_led_power[0];
	// Disk shows the bottom bit of its code
	assign led_d  = i_led_disk[0];
	assign status = {3'b000, led_p, 1'b0, led_d, 1'b0, i_led_user};

	// Host mask overrides the status bits one by one
	assign o_led = (i_led_overtake & i_led_state) | (~i_led_overtake & status);

endmodule

/* design/sys_top.sv */
`timescale 1ns/1ns

module sys_top
	import sys_pkg::*;
#(
	parameter int DEB_DIV = 100000
) (
	input  logic       clk,
	input  logic       resetd,

	// Host command channel
	input  logic       i_io_clk,
	input  logic       i_io_uio,
	input  host_word_t i_io_din,
	output logic       o_io_ack,

	// Audio
	input  sample_t    i_audio_l,
	input  sample_t    i_audio_r,
	input  logic       i_audio_signed,
	input  mix_t       i_audio_mix,
	input  sample_t    i_linux_l,
	input  sample_t    i_linux_r,
	output sample_t    o_audio_l,
	output sample_t    o_audio_r,

	// Front panel
	input  logic       i_key_user_n,
	input  logic       i_key_osd_n,
	input  logic [1:0] i_core_btn,
	input  logic       i_led_user,
	input  logic [1:0] i_led_power,
	input  logic [1:0] i_led_disk,
	output logic       o_btn_user,
	output logic       o_btn_osd,
	output led_t       o_led
);

	att_t    vol_att;
	led_t    led_overtake;
	led_t    led_state;
	sample_t pre_l;
	sample_t pre_r;

	////////////////////////////////////////////////////////////////////////////
	// Host channel

	host_cmd u_host_cmd (
		.clk            (clk),
		.resetd         (resetd),
		.i_io_clk       (i_io_clk),
		.i_io_uio       (i_io_uio),
		.i_io_din       (i_io_din),
		.o_io_ack       (o_io_ack),
		.o_vol_att      (vol_att),
		.o_led_overtake (led_overtake),
		.o_led_state    (led_state)
	);

	////////////////////////////////////////////////////////////////////////////
	// Audio, pre-mix of each side crosses to the other

	audio_mix_channel u_mix_l (
		.clk         (clk),
		.resetd      (resetd),
		.i_att       (vol_att),
		.i_mix       (i_audio_mix),
		.i_is_signed (i_audio_signed),
		.i_core      (i_audio_l),
		.i_linux     (i_linux_l),
		.i_pre_in    (pre_r),
		.o_pre_out   (pre_l),
		.o_out       (o_audio_l)
	);

	audio_mix_channel u_mix_r (
		.clk         (clk),
		.resetd      (resetd),
		.i_att       (vol_att),
		.i_mix       (i_audio_mix),
		.i_is_signed (i_audio_signed),
		.i_core      (i_audio_r),
		.i_linux     (i_linux_r),
		.i_pre_in    (pre_l),
		.o_pre_out   (pre_r),
		.o_out       (o_audio_r)
	);

	////////////////////////////////////////////////////////////////////////////
	// Front panel

	panel_io #(.DEB_DIV(DEB_DIV)) u_panel_io (
		.clk            (clk),
		.resetd         (resetd),
		.i_key_user_n   (i_key_user_n),
		.i_key_osd_n    (i_key_osd_n),
		.i_core_btn     (i_core_btn),
		.i_led_user     (i_led_user),
		.i_led_power    (i_led_power),
		.i_led_disk     (i_led_disk),
		.i_led_overtake (led_overtake),
		.i_led_state    (led_state),
		.o_btn_user     (o_btn_user),
		.o_btn_osd      (o_btn_osd),
		.o_led          (o_led)
	);

endmodule

/* test/sys_top_properties.sv */
`timescale 1ns/1ns

module sys_top_properties
	import sys_pkg::*;
(
	input logic    clk,
	input logic    resetd,
	input logic    io_ack,
	input logic    word_stb,
	input logic    uio,
	input att_t    vol_att,
	input att_t    att,
	input sample_t out_l,
	input sample_t out_r
);

	// Ack is held low through reset
	ack_low_in_reset: assert property (@(posedge clk) resetd |=> !io_ack)
		else $error("o_io_ack high during reset");

	// Volume moves only on a word with select high
	vol_on_strobe: assert property (@(posedge clk) disable iff (resetd)
		(vol_att != $past(vol_att)) |-> $past(word_stb && uio))
		else $error("o_vol_att changed without a host word");

	// Mute clears both outputs once it has passed the pipeline
	mute_clears_out: assert property (@(posedge clk) disable iff (resetd)
		(att[4] && $past(att[4]) && $past(att[4], 2) && $past(att[4], 3))
		|-> (out_l == '0 && out_r == '0))
		else $error("audio output not zero while muted");

endmodule

bind sys_top sys_top_properties u_props (
	.clk      (clk),
	.resetd   (resetd),
	.io_ack   (o_io_ack),
	.word_stb (u_host_cmd.word_stb),
	.uio      (u_host_cmd.uio_r),
	.vol_att  (vol_att),
	.att      (vol_att),
	.out_l    (o_audio_l),
	.out_r    (o_audio_r)
);

/* test/tb_sys_top.sv */
`timescale 1ns/1ns

module tb_sys_top
	import sys_pkg::*;
;

	// Rough cycle budget of all tests together
	localparam int TEST_CYCLES = 400 + 1800 + 9000 + 250 + 100;

	logic       clk;
	logic       resetd;
	logic       io_clk;
	logic       io_uio;
	host_word_t io_din;
	logic       io_ack;
	sample_t    audio_l_in;
	sample_t    audio_r_in;
	logic       audio_signed;
	mix_t       audio_mix;
	sample_t    linux_l;
	sample_t    linux_r;
	sample_t    audio_l_out;
	sample_t    audio_r_out;
	logic       key_user_n;
	logic       key_osd_n;
	logic [1:0] core_btn;
	logic       led_user;
	logic [1:0] led_power;
	logic [1:0] led_disk;
	logic       btn_user;
	logic       btn_osd;
	led_t       led;

	integer seed = 32'h1efe3875;
	led_t   mdl_mask;
	led_t   mdl_state;

	sys_top #(.DEB_DIV(3)) uut (
		.clk            (clk),
		.resetd         (resetd),
		.i_io_clk       (io_clk),
		.i_io_uio       (io_uio),
		.i_io_din       (io_din),
		.o_io_ack       (io_ack),
		.i_audio_l      (audio_l_in),
		.i_audio_r      (audio_r_in),
		.i_audio_signed (audio_signed),
		.i_audio_mix    (audio_mix),
		.i_linux_l      (linux_l),
		.i_linux_r      (linux_r),
		.o_audio_l      (audio_l_out),
		.o_audio_r      (audio_r_out),
		.i_key_user_n   (key_user_n),
		.i_key_osd_n    (key_osd_n),
		.i_core_btn     (core_btn),
		.i_led_user     (led_user),
		.i_led_power    (led_power),
		.i_led_disk     (led_disk),
		.o_btn_user     (btn_user),
		.o_btn_osd      (btn_osd),
		.o_led          (led)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	task automatic stop_failed(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("** Error %s: expected %h, actual %h", name, exp, act);
			stop_failed("Value mismatch");
		end
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (io_ack !== level) begin
			step(1);
			n++;
			if (n > 20)
				stop_failed("Host acknowledge never followed the strobe");
		end
	endtask

	task automatic send_word(input host_word_t w);
		io_din = w;
		io_clk = 1'b1;
		wait_ack(1'b1);
		io_clk = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic start_transfer(input cmd_code_t cmd);
		io_uio = 1'b1;
		send_word({8'h00, cmd});
	endtask

	task automatic end_transfer();
		io_uio = 1'b0;
		step(4);
	endtask

	function automatic led_t status_byte(input logic u, input logic [1:0] p, input logic [1:0] d);
		logic pw;
		pw = (p == 2'b11);
		status_byte = 8'h00;
		status_byte[4] = pw;
		status_byte[2] = d[0];
		status_byte[0] = u;
	endfunction

	// Each LED bit follows the host state where the mask is set
	function automatic led_t led_expect(input led_t mask, input led_t state,
			input led_t status);
		led_t e;
		for (int b = 0; b < 8; b++)
			e[b] = mask[b] ? state[b] : status[b];
		led_expect = e;
	endfunction

	// PCM sum of one side, range fits 17 bits signed
	function automatic int pcm_sum(input sample_t core, input sample_t lin, input logic sgn);
		int c;
		int l;
		if (sgn)
			c = $signed(core);
		else
			c = core >> 1;
		l = $signed(lin);
		pcm_sum = c + l;
	endfunction

	function automatic sample_t mix_out(input int sum, input int other, input mix_t m,
			input att_t a);
		int v;
		case (m)
			2'd0: v = sum;
			2'd1: v = sum - (sum >>> 3) + ((other >>> 1) >>> 2);
			2'd2: v = sum - (sum >>> 2) + ((other >>> 1) >>> 1);
			default: v = (sum >>> 1) + (other >>> 1);
		endcase
		if (a[4])
			v = 0;
		else
			v = v >>> a[3:0];
		if (v > 32767)
			v = 32767;
		if (v < -32768)
			v = -32768;
		mix_out = v[15:0];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Tests

	initial begin
		int   sum_l;
		int   sum_r;
		int   n;
		att_t att;
		cmd_code_t cmd;

		resetd = 1'b1;
		io_clk = 1'b0;
		io_uio = 1'b0;
		io_din = '0;
		audio_l_in = '0;
		audio_r_in = '0;
		audio_signed = 1'b0;
		audio_mix = '0;
		linux_l = '0;
		linux_r = '0;
		key_user_n = 1'b1;
		key_osd_n = 1'b1;
		core_btn = '0;
		led_user = 1'b1;
		led_power = 2'b11;
		led_disk = 2'b01;
		mdl_mask = '0;
		mdl_state = '0;

		step(5);
		resetd = 1'b0;
		step(1);
		check("reset_ack", 0, io_ack);
		check("reset_btn_user", 0, btn_user);
		check("reset_btn_osd", 0, btn_osd);
		check("reset_audio_l", 0, audio_l_out);
		check("reset_audio_r", 0, audio_r_out);
		check("reset_led", status_byte(1'b1, 2'b11, 2'b01), led);

		// Handshake with select low, ack trails by 4 cycles
		for (int i = 0; i < 40; i++) begin
			io_din = $random(seed);
			io_clk = ~io_clk;
			step(2);
			check("ack_early", !io_clk, io_ack);
			step(2);
			check("ack_follow", io_clk, io_ack);
		end
		io_clk = 1'b0;
		wait_ack(1'b0);

		// LED mask and state with unknown commands between
		for (int i = 0; i < 30; i++) begin
			led_user = $random(seed);
			led_power = $random(seed);
			led_disk = $random(seed);
			n = 1 + ($random(seed) & 32'h1);
			start_transfer(CMD_LED);
			for (int k = 0; k < n; k++) begin
				{mdl_mask, mdl_state} = $random(seed);
				send_word({mdl_mask, mdl_state});
			end
			end_transfer();
			check("led_cmd", led_expect(mdl_mask, mdl_state,
				status_byte(led_user, led_power, led_disk)), led);
			cmd = $random(seed);
			if (cmd == CMD_LED || cmd == CMD_VOLUME)
				cmd = 8'h30;
			start_transfer(cmd);
			send_word($random(seed));
			end_transfer();
			check("led_unknown", led_expect(mdl_mask, mdl_state,
				status_byte(led_user, led_power, led_disk)), led);
		end

		// Mixer rounds, volume set through the host
		for (int i = 0; i < 200; i++) begin
			att = $random(seed);
			start_transfer(CMD_VOLUME);
			send_word({11'h0, att});
			end_transfer();
			audio_l_in = $random(seed);
			audio_r_in = $random(seed);
			linux_l = $random(seed);
			linux_r = $random(seed);
			audio_signed = $random(seed);
			audio_mix = $random(seed);
			step(12);
			sum_l = pcm_sum(audio_l_in, linux_l, audio_signed);
			sum_r = pcm_sum(audio_r_in, linux_r, audio_signed);
			check("audio_l", mix_out(sum_l, sum_r, audio_mix, att), audio_l_out);
			check("audio_r", mix_out(sum_r, sum_l, audio_mix, att), audio_r_out);
		end

		// Debounce, one sample every 4 cycles
		key_user_n = 1'b0;
		step(44);
		check("deb_press", 1, btn_user);
		key_user_n = 1'b1;
		step(8);
		check("deb_glitch", 1, btn_user);
		step(44);
		check("deb_release", 0, btn_user);
		core_btn = 2'b10;
		step(1);
		check("core_user", 1, btn_user);
		check("core_user_osd", 0, btn_osd);
		core_btn = 2'b01;
		step(1);
		check("core_osd", 1, btn_osd);
		check("core_osd_user", 0, btn_user);
		core_btn = 2'b00;
		step(1);
		check("core_off", 0, btn_osd);

		$display("** PASS **");
		$finish;
	end

	initial begin
		#(TEST_CYCLES * 2 * 10);
		stop_failed("Timeout, the tests did not finish in time");
	end

endmodule

/* all.f */
design/sys_pkg.sv
design/host_cmd.sv
design/audio_mix_channel.sv
design/btn_debounce.sv
design/panel_io.sv
design/sys_top.sv
test/sys_top_properties.sv
test/tb_sys_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
	--top-module tb_sys_top -f all.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb 2>&1 | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
	echo "Simulation returned status $status"
fi

if grep -q "\*\* PASS \*\*" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
